// ==== common/icache_params.svh ====
// Instruction cache sizing parameters
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ==========================================================================
// Cache geometry
// ==========================================================================

// Lines per bank, every bank fully associative
`define ICACHE_WAYS 8

// Width of a way index inside one bank
`define ICACHE_WAY_BITS 3

// ==========================================================================
// Miss handling and memory interface
// ==========================================================================

// Outstanding line misses tracked at once
`define MSHR_ENTRIES 4

// Memory transaction tag width, tag zero means no transaction
`define MEM_TAG_BITS 4

// ==========================================================================
// Replacement
// ==========================================================================

// Victim LFSR reset value, must not be all ones
`define LFSR_SEED 3'b001

`endif

// ==== common/icache_pkg.sv ====
// Instruction cache shared types
`include "icache_params.svh"

package icache_pkg;

    // ======================================================================
    // Basic widths
    // ======================================================================

    // Byte address from fetch and to memory
    typedef logic [31:0] addr_t;

    // One cache line, 8 bytes
    typedef logic [63:0] mem_block_t;

    // Memory transaction tag, zero when idle or rejected
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // Address bits above the bank select bit
    typedef logic [27:0] itag_t;

    // ======================================================================
    // Bundles
    // ======================================================================

    // Fetch request for one read port
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    // Line plus valid, used for fills and read results
    typedef struct packed {
        logic       valid;
        mem_block_t cache_line;
    } cache_line_t;

    // Line leaving the cache with its block address
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        mem_block_t data;
    } evict_t;

    // ======================================================================
    // Encodings
    // ======================================================================

    // Memory command
    typedef enum logic [1:0] {
        MEM_NONE = 2'b00,
        MEM_LOAD = 2'b01
    } mem_command_t;

    // MSHR entry state
    typedef enum logic [1:0] {
        MSHR_FREE  = 2'b00,
        MSHR_ISSUE = 2'b01,
        MSHR_WAIT  = 2'b10
    } mshr_state_t;

endpackage

// ==== icache/lfsr_evict.sv ====
// Victim way LFSR
`include "icache_params.svh"

module lfsr_evict (
    input  logic                        clock,
    input  logic                        reset,
    output logic [`ICACHE_WAY_BITS-1:0] way
);

    // Shift register state
    logic [`ICACHE_WAY_BITS-1:0] lfsr_q;
    // New bit shifted in at the bottom
    logic                        feedback;

    // XNOR of the two top taps, x^3 + x^2 + 1
    // All ones is the lock-up state and is never entered from the seed
    always_comb begin
        feedback = ~(lfsr_q[2] ^ lfsr_q[1]);
    end

    // Advances every cycle whether or not a fill happens
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr_q <= `LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[1:0], feedback};
        end
    end

    // Current state is the victim way
    assign way = lfsr_q;

endmodule

// ==== icache/icache.sv ====
// Two-bank fully associative instruction cache
`include "icache_params.svh"

module icache (
    input  logic                          clock,
    input  logic                          reset,
    input  icache_pkg::fetch_req_t  [1:0] fetch,
    output icache_pkg::cache_line_t [1:0] read_out,
    output logic                    [1:0] miss,
    input  icache_pkg::addr_t             fill_addr,
    input  icache_pkg::cache_line_t       fill,
    output icache_pkg::evict_t            evict
);
    import icache_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================
    // Address layout: [31:4] tag, [3] bank, [2:0] byte offset

    // Valid bits per bank and way
    logic  [1:0][`ICACHE_WAYS-1:0] valids;
    // Tags per bank and way
    itag_t [1:0][`ICACHE_WAYS-1:0] tags;
    // Line data per bank and way
    mem_block_t                    lines [2][`ICACHE_WAYS];

    // Read side
    logic [1:0]                        port_bank;
    logic [1:0]                        port_hit;
    logic [1:0][`ICACHE_WAY_BITS-1:0]  hit_way;

    // Fill side
    logic                        fill_bank;
    logic                        bank_full;
    logic [`ICACHE_WAY_BITS-1:0] free_way;
    logic [`ICACHE_WAY_BITS-1:0] fill_way;
    logic [`ICACHE_WAY_BITS-1:0] lfsr_way;

    // Pseudo random victim for full banks
    lfsr_evict lfsr_i (
        .clock (clock),
        .reset (reset),
        .way   (lfsr_way)
    );

    // ======================================================================
    // Read ports
    // ======================================================================

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            port_bank[p] = fetch[p].addr[3];
            port_hit[p]  = 1'b0;
            hit_way[p]   = '0;
            // Full compare against every way of the selected bank
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (valids[port_bank[p]][w] &&
                    tags[port_bank[p]][w] == fetch[p].addr[31:4]) begin
                    port_hit[p] = 1'b1;
                    hit_way[p]  = w[`ICACHE_WAY_BITS-1:0];
                end
            end
            // Only a true tag miss goes to the MSHR
            miss[p] = fetch[p].valid && !port_hit[p];
            // Bank busy with a fill this cycle, fetch sees no data and retries
            read_out[p].valid      = fetch[p].valid && port_hit[p] &&
                                     !(fill.valid && fill_bank == port_bank[p]);
            read_out[p].cache_line = lines[port_bank[p]][hit_way[p]];
        end
    end

    // ======================================================================
    // Fill way selection and eviction
    // ======================================================================

    always_comb begin
        fill_bank = fill_addr[3];
        bank_full = &valids[fill_bank];
        // Lowest invalid way, scanned from the top so the lowest wins
        free_way = '0;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valids[fill_bank][w]) begin
                free_way = w[`ICACHE_WAY_BITS-1:0];
            end
        end
        fill_way = bank_full ? lfsr_way : free_way;

        // Old line goes out with its rebuilt block address
        evict.valid = fill.valid && bank_full;
        evict.addr  = {tags[fill_bank][fill_way], fill_bank, 3'b000};
        evict.data  = lines[fill_bank][fill_way];
    end

    // Valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            valids <= '0;
        end else if (fill.valid) begin
            valids[fill_bank][fill_way] <= 1'b1;
        end
    end

    // Tag and line arrays, qualified by the valid bits
    always_ff @(posedge clock) begin
        if (fill.valid) begin
            tags[fill_bank][fill_way]  <= fill_addr[31:4];
            lines[fill_bank][fill_way] <= fill.cache_line;
        end
    end

endmodule

// ==== hdl/mshr.sv ====
// Miss status holding registers
`include "icache_params.svh"

module mshr (
    input  logic                         clock,
    input  logic                         reset,
    input  icache_pkg::fetch_req_t [1:0] fetch,
    input  logic                   [1:0] miss,
    input  icache_pkg::mem_tag_t         mem_transaction_tag,
    input  icache_pkg::mem_tag_t         mem_data_tag,
    input  icache_pkg::mem_block_t       mem_data,
    output logic                         mem_req_valid,
    output icache_pkg::addr_t            mem_req_addr,
    output icache_pkg::mem_command_t     mem_req_command,
    output icache_pkg::addr_t            fill_addr,
    output icache_pkg::cache_line_t      fill
);
    import icache_pkg::*;

    localparam int IDX_BITS = $clog2(`MSHR_ENTRIES);

    // Entry state
    mshr_state_t state      [`MSHR_ENTRIES];
    addr_t       entry_addr [`MSHR_ENTRIES];
    mem_tag_t    entry_tag  [`MSHR_ENTRIES];

    // Allocation
    addr_t [1:0]         miss_block;
    logic  [1:0]         pending;
    logic  [1:0]         want;
    logic                free_found0;
    logic                free_found1;
    logic [IDX_BITS-1:0] free_idx0;
    logic [IDX_BITS-1:0] free_idx1;
    logic                alloc0;
    logic                alloc1;
    logic [IDX_BITS-1:0] alloc_idx1;

    // Request and return
    logic                req_found;
    logic [IDX_BITS-1:0] req_idx;
    logic                accept;
    logic                data_found;
    logic [IDX_BITS-1:0] data_idx;

    // ======================================================================
    // Lookup and allocation
    // ======================================================================

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            miss_block[p] = {fetch[p].addr[31:3], 3'b000};
            // Any busy entry for this block, the one being filled included
            pending[p] = 1'b0;
            for (int i = 0; i < `MSHR_ENTRIES; i++) begin
                if (state[i] != MSHR_FREE && entry_addr[i] == miss_block[p]) begin
                    pending[p] = 1'b1;
                end
            end
        end
        want[0] = miss[0] && !pending[0];
        // Same block on both ports merges into port 0
        want[1] = miss[1] && !pending[1] && !(miss[0] && miss_block[1] == miss_block[0]);

        // Two lowest free entries
        free_found0 = 1'b0;
        free_found1 = 1'b0;
        free_idx0   = '0;
        free_idx1   = '0;
        for (int i = 0; i < `MSHR_ENTRIES; i++) begin
            if (state[i] == MSHR_FREE) begin
                if (!free_found0) begin
                    free_found0 = 1'b1;
                    free_idx0   = i[IDX_BITS-1:0];
                end else if (!free_found1) begin
                    free_found1 = 1'b1;
                    free_idx1   = i[IDX_BITS-1:0];
                end
            end
        end

        // Port 1 takes the next entry when port 0 allocates too
        alloc0     = want[0] && free_found0;
        alloc1     = want[1] && (want[0] ? free_found1 : free_found0);
        alloc_idx1 = want[0] ? free_idx1 : free_idx0;
    end

    // ======================================================================
    // Memory request and data return
    // ======================================================================

    always_comb begin
        // Lowest entry waiting to issue
        req_found = 1'b0;
        req_idx   = '0;
        for (int i = `MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (state[i] == MSHR_ISSUE) begin
                req_found = 1'b1;
                req_idx   = i[IDX_BITS-1:0];
            end
        end
        mem_req_valid   = req_found;
        mem_req_addr    = req_found ? entry_addr[req_idx] : '0;
        mem_req_command = req_found ? MEM_LOAD : MEM_NONE;
        // Zero tag is a rejection, request held
        accept = req_found && mem_transaction_tag != '0;

        // Returning tag against waiting entries
        data_found = 1'b0;
        data_idx   = '0;
        for (int i = 0; i < `MSHR_ENTRIES; i++) begin
            if (mem_data_tag != '0 && state[i] == MSHR_WAIT &&
                entry_tag[i] == mem_data_tag) begin
                data_found = 1'b1;
                data_idx   = i[IDX_BITS-1:0];
            end
        end
        fill.valid      = data_found;
        fill.cache_line = mem_data;
        fill_addr       = entry_addr[data_idx];
    end

    // State updates, the indices always point at different entries
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MSHR_ENTRIES; i++) begin
                state[i] <= MSHR_FREE;
            end
        end else begin
            if (accept) state[req_idx] <= MSHR_WAIT;
            if (data_found) state[data_idx] <= MSHR_FREE;
            if (alloc0) state[free_idx0] <= MSHR_ISSUE;
            if (alloc1) state[alloc_idx1] <= MSHR_ISSUE;
        end
    end

    // Block address and memory tag per entry
    always_ff @(posedge clock) begin
        if (alloc0) entry_addr[free_idx0] <= miss_block[0];
        if (alloc1) entry_addr[alloc_idx1] <= miss_block[1];
        if (accept) entry_tag[req_idx] <= mem_transaction_tag;
    end

endmodule

// ==== hdl/icache_subsystem.sv ====
// Instruction cache subsystem top level
module icache_subsystem (
    input  logic                         clock,
    input  logic                         reset,
    // Fetch side, two read ports
    input  icache_pkg::fetch_req_t [1:0] fetch,
    output icache_pkg::mem_block_t [1:0] icache_data,
    output logic                   [1:0] icache_valid,
    // Memory side
    input  icache_pkg::mem_tag_t         mem_transaction_tag,
    input  icache_pkg::mem_tag_t         mem_data_tag,
    input  icache_pkg::mem_block_t       mem_data,
    output logic                         mem_req_valid,
    output icache_pkg::addr_t            mem_req_addr,
    output icache_pkg::mem_command_t     mem_req_command,
    // Evicted lines for a later victim cache
    output icache_pkg::evict_t           evict
);
    import icache_pkg::*;

    // Cache to MSHR and back
    cache_line_t [1:0] read_out;
    logic        [1:0] miss;
    addr_t             fill_addr;
    cache_line_t       fill;

    // ======================================================================
    // Cache
    // ======================================================================

    icache icache_i (
        .clock     (clock),
        .reset     (reset),
        .fetch     (fetch),
        .read_out  (read_out),
        .miss      (miss),
        .fill_addr (fill_addr),
        .fill      (fill),
        .evict     (evict)
    );

    // Split read results per port
    for (genvar p = 0; p < 2; p++) begin : gen_port
        assign icache_data[p]  = read_out[p].cache_line;
        assign icache_valid[p] = read_out[p].valid;
    end

    // ======================================================================
    // Miss handling
    // ======================================================================

    mshr mshr_i (
        .clock               (clock),
        .reset               (reset),
        .fetch               (fetch),
        .miss                (miss),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_req_valid       (mem_req_valid),
        .mem_req_addr        (mem_req_addr),
        .mem_req_command     (mem_req_command),
        .fill_addr           (fill_addr),
        .fill                (fill)
    );

endmodule

// ==== tb/mem_model.sv ====
// Behavioral instruction memory
module mem_model (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     mem_req_valid,
    input  icache_pkg::addr_t        mem_req_addr,
    input  icache_pkg::mem_command_t mem_req_command,
    output icache_pkg::mem_tag_t     mem_transaction_tag,
    output icache_pkg::mem_tag_t     mem_data_tag,
    output icache_pkg::mem_block_t   mem_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    // Cycles from acceptance to the data tag
    localparam int LATENCY = 4;

    // Next tag to hand out
    mem_tag_t next_tag;
    logic     accepted;
    // Return pipeline with one slot per cycle of latency
    mem_tag_t pipe_tag  [LATENCY];
    addr_t    pipe_addr [LATENCY];
    // Accepted loads per block address
    int       req_count [addr_t];

    // Zero tag while stalled is the rejection
    assign mem_transaction_tag = (mem_req_valid && mem_req_command == MEM_LOAD && !stall) ?
                                 next_tag : '0;
    assign accepted = mem_transaction_tag != '0;

    // Rotates from 1 up to all ones and never gives zero
    always @(posedge clock) begin
        if (reset) begin
            next_tag <= mem_tag_t'(1);
        end else if (accepted) begin
            next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
        end
    end

    // Tag and address travel together down the pipe
    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i]  <= '0;
                pipe_addr[i] <= '0;
            end
        end else begin
            pipe_tag[0]  <= accepted ? mem_transaction_tag : '0;
            pipe_addr[0] <= mem_req_addr;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_addr[i] <= pipe_addr[i-1];
            end
        end
    end

    // Line for block A is A followed by its inverse
    assign mem_data_tag = pipe_tag[LATENCY-1];
    assign mem_data     = {pipe_addr[LATENCY-1], ~pipe_addr[LATENCY-1]};

    // Count accepted loads
    always @(posedge clock) begin
        if (reset) begin
            req_count.delete();
        end else if (accepted) begin
            if (req_count.exists(mem_req_addr)) begin
                req_count[mem_req_addr] = req_count[mem_req_addr] + 1;
            end else begin
                req_count[mem_req_addr] = 1;
            end
        end
    end

endmodule

// ==== tb/icache_subsystem_tb.sv ====
// Instruction cache subsystem testbench
module icache_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    // ======================================================================
    // Timing and run length
    // ======================================================================
    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    // Cycles allowed for one fetch to hit or one request to show
    localparam int MAX_WAIT = 40;
    // Bounded waits summed over all tests
    localparam int BOUNDED_WAITS = 19;
    // Six resets plus the bounded waits and the fixed stretches of the tests
    localparam int RUN_CYCLES = 6 * (RESET_CYCLES + 2) + BOUNDED_WAITS * MAX_WAIT + 60;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

    logic             clock;
    logic             reset;
    logic             stall;
    fetch_req_t [1:0] fetch;
    mem_block_t [1:0] icache_data;
    logic       [1:0] icache_valid;
    mem_tag_t         mem_transaction_tag;
    mem_tag_t         mem_data_tag;
    mem_block_t       mem_data;
    logic             mem_req_valid;
    addr_t            mem_req_addr;
    mem_command_t     mem_req_command;
    evict_t           evict;

    integer seed = 32'hd6d3c9c8;
    int     errors = 0;
    int     checks = 0;

    // Seen by the monitor since the last reset
    addr_t      requested [$];
    int         evict_count;
    addr_t      evict_addr;
    mem_block_t evict_data;

    icache_subsystem dut_i (
        .clock               (clock),
        .reset               (reset),
        .fetch               (fetch),
        .icache_data         (icache_data),
        .icache_valid        (icache_valid),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_req_valid       (mem_req_valid),
        .mem_req_addr        (mem_req_addr),
        .mem_req_command     (mem_req_command),
        .evict               (evict)
    );

    mem_model mem_i (
        .clock               (clock),
        .reset               (reset),
        .stall               (stall),
        .mem_req_valid       (mem_req_valid),
        .mem_req_addr        (mem_req_addr),
        .mem_req_command     (mem_req_command),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Requests and evictions sampled mid cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (mem_req_valid) begin
                requested.push_back(mem_req_addr);
            end
            if (evict.valid) begin
                evict_count = evict_count + 1;
                evict_addr  = evict.addr;
                evict_data  = evict.data;
            end
        end
    end

    // ======================================================================
    // Reference rules and checks
    // ======================================================================

    function automatic addr_t block_of(input addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    // Block address followed by its bitwise inverse
    function automatic mem_block_t expected_line(input addr_t a);
        return {block_of(a), ~block_of(a)};
    endfunction

    function automatic addr_t random_addr(input logic bank);
        addr_t r;
        r = $random(seed);
        r[3] = bank;
        return r;
    endfunction

    function automatic logic was_requested(input addr_t block);
        logic seen;
        seen = 1'b0;
        foreach (requested[i]) begin
            if (requested[i] == block) begin
                seen = 1'b1;
            end
        end
        return seen;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input mem_block_t got, input mem_block_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("At %0t ns: %s", $time, what);
        end
    endtask

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        stall <= 1'b0;
        fetch <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        requested.delete();
        evict_count = 0;
    endtask

    task automatic idle_fetch();
        @(posedge clock);
        fetch <= '0;
    endtask

    // Holds the addresses until every used port hits and checks the data on each hit
    task automatic fetch_until_hit(input addr_t a0, input logic use0,
                                   input addr_t a1, input logic use1);
        logic [1:0] done;
        int         waited;
        done   = {~use1, ~use0};
        waited = 0;
        @(posedge clock);
        fetch[0].valid <= use0;
        fetch[0].addr  <= a0;
        fetch[1].valid <= use1;
        fetch[1].addr  <= a1;
        while (done != 2'b11 && waited < MAX_WAIT) begin
            @(negedge clock);
            waited++;
            if (!done[0] && icache_valid[0]) begin
                done[0] = 1'b1;
                check_block("icache_data[0]", icache_data[0], expected_line(a0));
            end
            if (!done[1] && icache_valid[1]) begin
                done[1] = 1'b1;
                check_block("icache_data[1]", icache_data[1], expected_line(a1));
            end
        end
        check_true(done == 2'b11, $sformatf("no hit for %h / %h within the wait", a0, a1));
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic reset_state_test();
        repeat (3) begin
            @(negedge clock);
            check_true(!mem_req_valid, "memory request raised after reset");
            check_true(icache_valid == 2'b00, "read data valid after reset");
            check_true(!evict.valid, "eviction raised after reset");
        end
    endtask

    task automatic cold_miss_test();
        addr_t a;
        int    waited;
        a = random_addr(1'($random(seed)));
        @(posedge clock);
        fetch[0].valid <= 1'b1;
        fetch[0].addr  <= a;
        @(negedge clock);
        check_true(!icache_valid[0], "cold address hit before any fill");
        // Request comes from the allocated entry one cycle later
        check_true(!mem_req_valid, "memory request in the same cycle as the miss");
        waited = 0;
        while (!mem_req_valid && waited < MAX_WAIT) begin
            @(negedge clock);
            waited++;
        end
        check_true(mem_req_valid, "no memory request after a cold miss");
        check_addr("mem_req_addr", mem_req_addr, block_of(a));
        check_true(mem_req_command == MEM_LOAD, "request command is not a load");
        fetch_until_hit(a, 1'b1, '0, 1'b0);
        idle_fetch();
        check_count("request count", mem_i.req_count[block_of(a)], 1);
    endtask

    task automatic dual_port_test();
        addr_t a0;
        addr_t a1;
        a0 = random_addr(1'b0);
        a1 = random_addr(1'b1);
        fetch_until_hit(a0, 1'b1, a1, 1'b1);
        idle_fetch();
        check_true(was_requested(block_of(a0)), "port 0 block never requested");
        check_true(was_requested(block_of(a1)), "port 1 block never requested");
        check_count("port 0 request count", mem_i.req_count[block_of(a0)], 1);
        check_count("port 1 request count", mem_i.req_count[block_of(a1)], 1);
    endtask

    task automatic merge_test();
        addr_t m;
        m = random_addr(1'($random(seed)));
        // Same block with another byte offset on port 1
        fetch_until_hit(m, 1'b1, {m[31:3], ~m[2:0]}, 1'b1);
        repeat (10) @(posedge clock);
        idle_fetch();
        check_count("merged request count", mem_i.req_count[block_of(m)], 1);
    endtask

    task automatic back_pressure_test();
        addr_t base;
        addr_t blocks [6];
        base = random_addr(1'b0);
        for (int i = 0; i < 6; i++) begin
            blocks[i] = {base[31:8], i[3:0], base[3:0]};
        end
        @(posedge clock);
        stall <= 1'b1;
        // Later misses fill the MSHR and the last two are dropped
        for (int i = 0; i < 6; i++) begin
            @(posedge clock);
            fetch[0].valid <= 1'b1;
            fetch[0].addr  <= blocks[i];
            for (int k = 0; k < 3; k++) begin
                @(negedge clock);
                if (i != 0 || k != 0) begin
                    check_true(mem_req_valid, "request dropped under back-pressure");
                    check_addr("mem_req_addr", mem_req_addr, block_of(blocks[0]));
                end
            end
        end
        @(posedge clock);
        fetch <= '0;
        stall <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            fetch_until_hit(blocks[i], 1'b1, '0, 1'b0);
        end
        idle_fetch();
        for (int i = 0; i < 6; i++) begin
            check_count("stalled block request count", mem_i.req_count[block_of(blocks[i])], 1);
        end
    endtask

    task automatic eviction_test();
        addr_t base;
        addr_t blocks [9];
        logic  found;
        base = random_addr(1'b0);
        // Distinct tags in bank 0
        for (int i = 0; i < 9; i++) begin
            blocks[i] = {base[31:8], i[3:0], 1'b0, base[2:0]};
        end
        for (int i = 0; i < 8; i++) begin
            fetch_until_hit(blocks[i], 1'b1, '0, 1'b0);
        end
        check_count("evictions before the bank is full", evict_count, 0);
        fetch_until_hit(blocks[8], 1'b1, '0, 1'b0);
        check_count("evictions on the ninth fill", evict_count, 1);
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (evict_addr == block_of(blocks[i])) begin
                found = 1'b1;
            end
        end
        check_true(found, $sformatf("evicted address %h was never filled", evict_addr));
        check_block("evict.data", evict_data, expected_line(evict_addr));
        idle_fetch();
        @(posedge clock);
        fetch[0].valid <= 1'b1;
        fetch[0].addr  <= evict_addr;
        @(negedge clock);
        check_true(!icache_valid[0], "evicted block still hits");
        idle_fetch();
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        fetch = '0;
        apply_reset();
        reset_state_test();
        apply_reset();
        cold_miss_test();
        apply_reset();
        dual_port_test();
        apply_reset();
        merge_test();
        apply_reset();
        back_pressure_test();
        apply_reset();
        eviction_test();
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Run stopped after %0d cycles without finishing the tests", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/icache_pkg.sv
icache/lfsr_evict.sv
icache/icache.sv
hdl/mshr.sv
hdl/icache_subsystem.sv
tb/mem_model.sv
tb/icache_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_subsystem_tb -f project.f -o sim > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/sim > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
